/* build.f */
logic/multihPkg.sv
logic/hostRegs.sv
logic/resetStretch.sv
logic/dacChannel.sv
logic/symbolRouter.sv
logic/multihTop.sv
verification/multihTb.sv

/* logic/dacChannel.sv */
/* Output is offset binary. In MultiH mode with a trellis select the output only
   moves on tap sync; otherwise it follows the external sample 3 cycles later. */
`default_nettype none

module dacChannel
  import multihPkg::*;
(
  input  wire logic             ck933,
  input  wire logic             rs,
  input  wire modeT             mode_i,
  input  wire dacSelT           select_i,
  input  wire logic [DAC_W-1:0] extData_i,
  input  wire trellisTapT       tap_i,
  output logic      [DAC_W-1:0] dacData_o
);

  logic [DAC_W-1:0] extReg;
  logic [DAC_W-1:0] selData;
  logic             selSync;
  logic             trellisSel;
  logic             trellisActive;

  always_comb begin
    case (select_i)
      DAC_TRELLIS_I,
      DAC_TRELLIS_Q,
      DAC_TRELLIS_PHERR,
      DAC_TRELLIS_INDEX: trellisSel = 1'b1;
      default:           trellisSel = 1'b0;
    endcase
  end

  assign trellisActive = trellisSel && (mode_i == MODE_MULTIH);

  // Input reclock
  always_ff @(posedge ck933) begin
    extReg <= extData_i;
  end

  //**********************************************************
  //  Source select
  //**********************************************************
  always_ff @(posedge ck933) begin
    if (trellisActive) begin
      selData <= tap_i.sample[TRELLIS_W-1 -: DAC_W];
    end else begin
      selData <= extReg;
    end
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      selSync <= 1'b0;
    end else begin
      selSync <= trellisActive ? tap_i.sync : 1'b1;  // External data always loads
    end
  end

  //**********************************************************
  //  Output register, MSB flipped for offset binary
  //**********************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dacData_o <= '0;
    end else if (selSync) begin
      dacData_o <= {~selData[DAC_W-1], selData[DAC_W-2:0]};
    end
  end

endmodule

`default_nettype wire

/* logic/hostRegs.sv */
/* Single bus master, one-cycle write strobes. Only the misc space is decoded here,
   every other address reads 0 and writes are dropped. */
`default_nettype none

module hostRegs
  import multihPkg::*;
(
  input  wire logic              ck933,
  input  wire logic              rs,
  input  wire hostBusT           hostBus_i,
  output logic      [DATA_W-1:0] rdata_o,
  output logic                   rdValid_o,
  output logic                   resetReq_o
);

  logic miscHit;
  logic versionHit;
  logic resetHit;
  logic resetWr;

  //**********************************************************
  //  Address decode
  //**********************************************************
  assign miscHit = (hostBus_i.addr[ADDR_W-1:MISC_SPAN_W] ==
                    MISC_BASE[ADDR_W-1:MISC_SPAN_W]);

  // Bit 0 is the half select, so match on the rest
  assign versionHit = miscHit &&
                      (hostBus_i.addr[MISC_SPAN_W-1:1] == MISC_VERSION[MISC_SPAN_W-1:1]);
  assign resetHit   = miscHit &&
                      (hostBus_i.addr[MISC_SPAN_W-1:1] == MISC_RESET[MISC_SPAN_W-1:1]);

  //**********************************************************
  //  Read path
  //**********************************************************
  assign rdValid_o = hostBus_i.cs & hostBus_i.rd;

  always_comb begin
    rdata_o = '0;
    if (rdValid_o && versionHit) begin
      if (hostBus_i.addr[0]) begin
        rdata_o = VERSION[2*DATA_W-1:DATA_W];  // High half
      end else begin
        rdata_o = VERSION[DATA_W-1:0];
      end
    end
  end

  //**********************************************************
  //  Software reset request
  //**********************************************************
  // Write data is ignored, any write to the register fires the request
  assign resetWr = hostBus_i.cs & hostBus_i.we & resetHit;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      resetReq_o <= 1'b0;
    end else begin
      resetReq_o <= resetWr;  // One cycle per write strobe
    end
  end

endmodule

`default_nettype wire

/* logic/multihPkg.sv */
/* Host addresses are 11-bit word addresses, and bit 0 picks the half of a 32-bit register.
   Mode and DAC select codes must track the register map of the demodulator cores. */
`default_nettype none

package multihPkg;

  //**********************************************************
  //  Widths and sizes
  //**********************************************************
  localparam int ADDR_W    = 11;     // Host word address
  localparam int DATA_W    = 16;
  localparam int DAC_W     = 14;
  localparam int TRELLIS_W = 18;     // DAC takes the upper DAC_W bits
  localparam int PHERR_W   = 8;
  localparam int NUM_DAC   = 3;

  localparam logic [2*DATA_W-1:0] VERSION = 32'h011c0000;

  // Internal reset is held this many cycles past the first one
  localparam int RESET_HOLD  = 5;
  localparam int RESET_CNT_W = $clog2(RESET_HOLD + 1);

  //**********************************************************
  //  Misc register space
  //**********************************************************
  localparam int MISC_SPAN_W = 4;    // 16 words
  localparam logic [ADDR_W-1:0] MISC_BASE    = 11'h7f0;
  localparam logic [ADDR_W-1:0] MISC_VERSION = MISC_BASE | 11'h000;  // Words 0 and 1
  localparam logic [ADDR_W-1:0] MISC_RESET   = MISC_BASE | 11'h002;  // Either half

  //**********************************************************
  //  Codes
  //**********************************************************
  typedef enum logic [3:0] {
    MODE_AUQPSK = 4'h6,
    MODE_MULTIH = 4'h9
  } modeT;

  // Sources that come out of the trellis core
  typedef enum logic [3:0] {
    DAC_TRELLIS_I     = 4'h8,
    DAC_TRELLIS_Q     = 4'h9,
    DAC_TRELLIS_PHERR = 4'ha,
    DAC_TRELLIS_INDEX = 4'hb
  } dacSelT;

  //**********************************************************
  //  Bundles
  //**********************************************************
  typedef struct packed {
    logic              cs;
    logic              we;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } hostBusT;

  typedef struct packed {
    logic [TRELLIS_W-1:0] sample;
    logic                 sync;    // Sample valid this cycle
  } trellisTapT;

  typedef struct packed {
    logic symEn;
    logic sym2xEn;
    logic iBit;
    logic qBit;
  } symbolT;

  typedef struct packed {
    logic [PHERR_W-1:0] value;
    logic               en;
    logic               valid;
  } pherrT;

endpackage

`default_nettype wire

/* logic/multihTop.sv */
/* Trellis results arrive as inputs from the external decoder core. A host write to
   MISC_RESET resets the data paths only; the register block keeps the rs pin. */
`default_nettype none

module multihTop
  import multihPkg::*;
(
  input  wire logic              ck933,
  input  wire logic              rs,
  // Host register bus
  input  wire hostBusT           hostBus_i,
  output wire logic [DATA_W-1:0] rdata_o,
  output wire logic              rdValid_o,
  // Demodulator side
  input  wire modeT              mode_i,
  input  wire dacSelT            dacSelect_i [NUM_DAC],
  input  wire logic [DAC_W-1:0]  extData_i [NUM_DAC],
  input  wire trellisTapT        tap_i [NUM_DAC],
  input  wire symbolT            trellis_i,
  input  wire symbolT            legacy_i,
  input  wire logic              auClk_i,
  input  wire pherrT             pherr_i,
  // Outputs
  output wire logic [DAC_W-1:0]  dacData_o [NUM_DAC],
  output wire symbolT            symbol_o,
  output wire logic              auQ_o,
  output wire logic              auClk_o,
  output wire pherrT             pherr_o
);

  logic resetReq;
  logic intReset;   // Data path reset

  //**********************************************************
  //  Register bus and reset
  //**********************************************************
  hostRegs uHostRegs (
    .ck933      (ck933),
    .rs         (rs),
    .hostBus_i  (hostBus_i),
    .rdata_o    (rdata_o),
    .rdValid_o  (rdValid_o),
    .resetReq_o (resetReq)
  );

  resetStretch uResetStretch (
    .ck933      (ck933),
    .rs         (rs),
    .resetReq_i (resetReq),
    .intReset_o (intReset)
  );

  //**********************************************************
  //  DAC channels
  //**********************************************************
  for (genvar gi = 0; gi < NUM_DAC; gi++) begin : gDac
    dacChannel uDacChannel (
      .ck933     (ck933),
      .rs        (intReset),
      .mode_i    (mode_i),
      .select_i  (dacSelect_i[gi]),
      .extData_i (extData_i[gi]),
      .tap_i     (tap_i[gi]),
      .dacData_o (dacData_o[gi])
    );
  end

  // Bit decoder feed and phase error
  symbolRouter uSymbolRouter (
    .ck933     (ck933),
    .rs        (intReset),
    .mode_i    (mode_i),
    .trellis_i (trellis_i),
    .legacy_i  (legacy_i),
    .auClk_i   (auClk_i),
    .pherr_i   (pherr_i),
    .symbol_o  (symbol_o),
    .auQ_o     (auQ_o),
    .auClk_o   (auClk_o),
    .pherr_o   (pherr_o)
  );

endmodule

`default_nettype wire

/* logic/resetStretch.sv */
/* intReset_o rises two cycles after a request and stays high RESET_HOLD+1 cycles.
   The rs pin forces it high with no clock. */
`default_nettype none

module resetStretch
  import multihPkg::*;
(
  input  wire logic ck933,
  input  wire logic rs,
  input  wire logic resetReq_i,
  output logic      intReset_o
);

  logic                   reqD1;
  logic                   reqD2;
  logic [RESET_CNT_W-1:0] holdCnt;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      reqD1   <= 1'b0;
      reqD2   <= 1'b0;
      holdCnt <= '0;
    end else begin
      reqD1 <= resetReq_i;
      reqD2 <= reqD1;
      if (reqD2) begin
        holdCnt <= RESET_CNT_W'(RESET_HOLD);  // A new request restarts the hold
      end else if (holdCnt != '0) begin
        holdCnt <= holdCnt - 1'b1;
      end
    end
  end

  // First cycle from the request pipe, the rest from the counter
  assign intReset_o = rs | reqD2 | (holdCnt != '0);

endmodule

`default_nettype wire

/* logic/symbolRouter.sv */
/* Trellis symbols pass in 1 cycle, legacy symbols in 3. auQ_o and auClk_o
   are live only in AUQPSK mode and read 0 in every other mode. */
`default_nettype none

module symbolRouter
  import multihPkg::*;
(
  input  wire logic   ck933,
  input  wire logic   rs,
  input  wire modeT   mode_i,
  input  wire symbolT trellis_i,
  input  wire symbolT legacy_i,
  input  wire logic   auClk_i,
  input  wire pherrT  pherr_i,
  output symbolT      symbol_o,
  output logic        auQ_o,
  output logic        auClk_o,
  output pherrT       pherr_o
);

  symbolT             legacyIn;    // Reclocked legacy bits
  symbolT             legacyDly;   // Legacy stage
  logic               auClkIn;
  logic               auqpskMode;
  logic [PHERR_W-1:0] pherrValue;
  logic               pherrEn;
  logic               pherrValid;

  assign auqpskMode = (mode_i == MODE_AUQPSK);

  //**********************************************************
  //  Decoder symbol select
  //**********************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      legacyIn  <= '0;
      legacyDly <= '0;
      auClkIn   <= 1'b0;
      symbol_o  <= '0;
    end else begin
      legacyIn  <= legacy_i;
      legacyDly <= legacyIn;
      auClkIn   <= auClk_i;
      if (mode_i == MODE_MULTIH) begin
        symbol_o <= trellis_i;  // Decisions are already registered in the core
      end else begin
        symbol_o <= legacyDly;
      end
    end
  end

  // AUQPSK bypasses the decoder for the Q channel
  assign auQ_o   = auqpskMode ? legacyIn.qBit : 1'b0;
  assign auClk_o = auqpskMode ? auClkIn : 1'b0;

  //**********************************************************
  //  Phase error feedback reclock
  //**********************************************************
  always_ff @(posedge ck933) begin
    pherrValue <= pherr_i.value;
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      pherrEn    <= 1'b0;
      pherrValid <= 1'b0;
    end else begin
      pherrEn    <= pherr_i.en;
      pherrValid <= pherr_i.valid;
    end
  end

  assign pherr_o = '{value: pherrValue, en: pherrEn, valid: pherrValid};

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compiles the multihTb testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 --top-module multihTb -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ/VmultihTb" > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
  echo "Result: failed, see $LOG"
  exit 1
fi

if [ $runStatus -ne 0 ]; then
  echo "Simulator exited with status $runStatus"
  exit 1
fi

echo "Result: passed"
exit 0

/* verification/multihTb.sv */
/* Random traffic from a fixed seed, checked each cycle against a cycle model of the pipelines.
   Software reset writes come only from the directed sequence. */
`default_nettype none

module multihTb
  import multihPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TRAFFIC_CYCLES = 300;

  logic              ck933;
  logic              rs;
  hostBusT           hostBus;
  logic [DATA_W-1:0] rdata;
  logic              rdValid;
  modeT              mode;
  dacSelT            dacSelect [NUM_DAC];
  logic [DAC_W-1:0]  extData [NUM_DAC];
  trellisTapT        tap [NUM_DAC];
  symbolT            trellis;
  symbolT            legacy;
  logic              auClk;
  pherrT             pherr;
  logic [DAC_W-1:0]  dacData [NUM_DAC];
  symbolT            symbol;
  logic              auQ;
  logic              auClkOut;
  pherrT             pherrOut;

  // Model state, one entry per pipeline stage
  logic [DAC_W-1:0]  extRegM [NUM_DAC];
  logic [DAC_W-1:0]  selDataM [NUM_DAC];
  logic              selSyncM [NUM_DAC];
  logic [DAC_W-1:0]  dacM [NUM_DAC];
  symbolT            legInM;
  symbolT            legDlyM;
  symbolT            symM;
  logic              auClkInM;
  pherrT             pherrM;

  logic              rsLevel;     // Level driven on rs at the next drive point
  int                edgeCount;
  int                swRstFirst;  // Edges whose flop state is the reset state
  int                swRstLast;

  multihTop DUT (
    .ck933       (ck933),
    .rs          (rs),
    .hostBus_i   (hostBus),
    .rdata_o     (rdata),
    .rdValid_o   (rdValid),
    .mode_i      (mode),
    .dacSelect_i (dacSelect),
    .extData_i   (extData),
    .tap_i       (tap),
    .trellis_i   (trellis),
    .legacy_i    (legacy),
    .auClk_i     (auClk),
    .pherr_i     (pherr),
    .dacData_o   (dacData),
    .symbol_o    (symbol),
    .auQ_o       (auQ),
    .auClk_o     (auClkOut),
    .pherr_o     (pherrOut)
  );

  always begin
    #2 ck933 = ~ck933;
  end

  //************************************************************
  //  Expected values
  //************************************************************
  function automatic logic isTrellisSel(dacSelT s);
    return s inside {DAC_TRELLIS_I, DAC_TRELLIS_Q, DAC_TRELLIS_PHERR, DAC_TRELLIS_INDEX};
  endfunction

  function automatic logic [DAC_W-1:0] offsetBinary(logic [DAC_W-1:0] s);
    return s ^ {1'b1, {(DAC_W-1){1'b0}}};
  endfunction

  function automatic logic [DATA_W-1:0] expectedRead(hostBusT b);
    if (!(b.cs && b.rd)) begin
      return '0;
    end
    if (b.addr == MISC_VERSION) begin
      return VERSION[DATA_W-1:0];
    end
    if (b.addr == (MISC_VERSION | 11'd1)) begin
      return VERSION[2*DATA_W-1:DATA_W];
    end
    return '0;
  endfunction

  //************************************************************
  //  Bus cycles
  //************************************************************
  function automatic hostBusT readBus(logic [ADDR_W-1:0] a);
    hostBusT b;
    b      = '0;
    b.cs   = 1'b1;
    b.rd   = 1'b1;
    b.addr = a;
    return b;
  endfunction

  function automatic hostBusT writeBus(logic [ADDR_W-1:0] a, logic [DATA_W-1:0] d);
    hostBusT b;
    b       = '0;
    b.cs    = 1'b1;
    b.we    = 1'b1;
    b.addr  = a;
    b.wdata = d;
    return b;
  endfunction

  function automatic hostBusT randomBus();
    hostBusT     b;
    logic [31:0] rnd;
    b   = '0;
    rnd = $urandom();
    case (rnd[1:0])
      2'd0: b = '0;
      2'd1: b = readBus(rnd[2] ? (MISC_VERSION | 11'd1) : MISC_VERSION);
      2'd2: begin
        // Half of these land in the misc space
        b    = readBus({rnd[3] ? MISC_BASE[ADDR_W-1:4] : rnd[14:8], rnd[7:4]});
        b.cs = rnd[15] | rnd[16];
      end
      default: begin
        b = writeBus({rnd[14:8], rnd[7:4]}, rnd[31:16]);
        if (b.addr[ADDR_W-1:1] == MISC_RESET[ADDR_W-1:1]) begin
          b.addr[ADDR_W-1] = 1'b0;  // Keep clear of the reset register
        end
      end
    endcase
    return b;
  endfunction

  //************************************************************
  //  Compare tasks
  //************************************************************
  task automatic stopOnError();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkDac(input string what, input logic [DAC_W-1:0] got,
                          input logic [DAC_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkSymbol(input symbolT got, input symbolT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: symbol_o is %b, expected %b", $time, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkPherr(input pherrT got, input pherrT exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: pherr_o is %h, expected %h", $time, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkRead(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: rdata_o is %h, expected %h", $time, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkBit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
      stopOnError();
    end
  endtask

  //************************************************************
  //  Cycle model, stimulus and per-cycle step
  //************************************************************
  task automatic stepModel();
    logic inReset;
    logic active;
    inReset = rs || (edgeCount >= swRstFirst && edgeCount <= swRstLast);
    for (int c = 0; c < NUM_DAC; c++) begin
      active = (mode == MODE_MULTIH) && isTrellisSel(dacSelect[c]);
      if (inReset) begin
        dacM[c] = '0;
      end else if (selSyncM[c]) begin
        dacM[c] = offsetBinary(selDataM[c]);  // Holds while sync is low
      end
      selSyncM[c] = inReset ? 1'b0 : (active ? tap[c].sync : 1'b1);
      selDataM[c] = active ? tap[c].sample[TRELLIS_W-1 -: DAC_W] : extRegM[c];
      extRegM[c]  = extData[c];
    end
    if (inReset) begin
      symM     = '0;
      legDlyM  = '0;
      legInM   = '0;
      auClkInM = 1'b0;
      pherrM.en    = 1'b0;
      pherrM.valid = 1'b0;
    end else begin
      symM     = (mode == MODE_MULTIH) ? trellis : legDlyM;
      legDlyM  = legInM;
      legInM   = legacy;
      auClkInM = auClk;
      pherrM.en    = pherr.en;
      pherrM.valid = pherr.valid;
    end
    pherrM.value = pherr.value;  // Data lane keeps loading through reset
  endtask

  task automatic compareOutputs();
    for (int c = 0; c < NUM_DAC; c++) begin
      checkDac($sformatf("dacData_o[%0d]", c), dacData[c], dacM[c]);
    end
    checkSymbol(symbol, symM);
    checkPherr(pherrOut, pherrM);
    checkBit("auQ_o", auQ, (mode == MODE_AUQPSK) ? legInM.qBit : 1'b0);
    checkBit("auClk_o", auClkOut, (mode == MODE_AUQPSK) ? auClkInM : 1'b0);
  endtask

  task automatic driveInputs(input hostBusT bus);
    logic [31:0] rnd;
    hostBus = bus;
    rs      = rsLevel;
    rnd     = $urandom();
    if (rnd[2:0] == 3'd0) begin  // Mode changes now and then
      case (rnd[4:3])
        2'd0, 2'd1: mode = MODE_MULTIH;
        2'd2:       mode = MODE_AUQPSK;
        default:    mode = modeT'(rnd[8:5]);
      endcase
    end
    for (int c = 0; c < NUM_DAC; c++) begin
      rnd = $urandom();
      if (rnd[2:0] == 3'd0) begin
        dacSelect[c] = rnd[3] ? dacSelT'({2'b10, rnd[5:4]}) : dacSelT'(rnd[9:6]);
      end
      extData[c]     = rnd[DAC_W+9:10];
      rnd            = $urandom();
      tap[c].sample  = rnd[TRELLIS_W-1:0];
      tap[c].sync    = (rnd[31:30] != 2'b00);
    end
    rnd     = $urandom();
    trellis = rnd[3:0];
    legacy  = rnd[7:4];
    auClk   = rnd[8];
    pherr   = rnd[18:9];
  endtask

  // Check just after the edge, then drive, then check the read lanes
  task automatic runCycle(input hostBusT bus);
    @(posedge ck933);
    edgeCount = edgeCount + 1;
    #1;
    stepModel();
    compareOutputs();
    driveInputs(bus);
    #1;
    checkRead(rdata, expectedRead(bus));
    checkBit("rdValid_o", rdValid, bus.cs & bus.rd);
  endtask

  task automatic softwareReset();
    int   waitCnt;
    logic cleared;
    runCycle(writeBus(MISC_RESET, 16'h0001));
    // Request lands on the next edge and the internal reset two edges after that.
    // Flops still see it on the edge where it drops, hence one extra edge.
    swRstFirst = edgeCount + 3;
    swRstLast  = edgeCount + RESET_HOLD + 4;
    waitCnt    = 0;
    cleared    = 1'b0;
    while (!cleared) begin
      if (waitCnt >= RESET_HOLD + 3) begin
        $display("Timeout: symbol and phase error outputs did not clear after a reset write");
        stopOnError();
      end else begin
        runCycle('0);
        waitCnt = waitCnt + 1;
        cleared = (symbol == '0) && !pherrOut.en && !pherrOut.valid;
      end
    end
  endtask

  //************************************************************
  //  Test sequence
  //************************************************************
  initial begin
    hostBusT noCs;
    void'($urandom(32'h25a8));
    ck933      = 1'b0;
    rs         = 1'b1;
    rsLevel    = 1'b1;
    hostBus    = '0;
    mode       = MODE_MULTIH;
    trellis    = '0;
    legacy     = '0;
    auClk      = 1'b0;
    pherr      = '0;
    edgeCount  = 0;
    swRstFirst = -100;
    swRstLast  = -100;
    for (int c = 0; c < NUM_DAC; c++) begin
      dacSelect[c] = DAC_TRELLIS_I;
      extData[c]   = '0;
      tap[c]       = '0;
    end

    repeat (15) runCycle(randomBus());
    rsLevel = 1'b0;  // Released at the next drive point

    // Version halves, unmapped words, rd without cs
    runCycle(readBus(MISC_VERSION));
    runCycle(readBus(MISC_VERSION | 11'd1));
    runCycle(readBus(11'h123));
    runCycle(readBus(MISC_RESET));
    noCs    = readBus(MISC_VERSION);
    noCs.cs = 1'b0;
    runCycle(noCs);

    repeat (TRAFFIC_CYCLES) runCycle(randomBus());
    softwareReset();
    repeat (TRAFFIC_CYCLES) runCycle(randomBus());
    softwareReset();
    repeat (50) runCycle(randomBus());

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
